// File: Makefile
# Verilator build and run of the cross-correlator testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module xc_tb -o Vxc_tb

# The run passes only if the pass message shows up in the simulator output
run: compile
	@out="$$(./obj_dir/Vxc_tb)"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir

// File: verif/xc_assertions.sv
// Bound protocol assertions
`timescale 1ns/1ps
`default_nettype none

module xc_assertions import xc_pkg::*; (
	input wire clk,
	input wire rst,
	input wire [2:0] req,
	input wire [2:0] gnt,
	input wire rd_gnt,
	input wire [2:0] rvalid,
	input wire axi_rvalid,
	input wire axi_rready,
	input wire [DATA_W-1:0] axi_rdata,
	input wire axi_bvalid,
	input wire axi_bready
);

	// **********************************************************
	// Arbiter
	// **********************************************************

	// At most one requester owns the RAM port, and only a requester that asks for it
	a_gnt_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(gnt) && ((gnt & ~req) == 3'b000))
		else $error("grant not one-hot or given without a request");

	// Read data comes back to the reader one cycle after its grant, and at no other time
	a_rvalid_follows: assert property (@(posedge clk) disable iff (rst)
		rvalid == ($past(rd_gnt) ? $past(gnt) : 3'b000))
		else $error("rvalid did not follow the read grant");

	// **********************************************************
	// AXI response channels
	// **********************************************************

	// A read response and its data hold until the master takes them
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata))
		else $error("RVALID or RDATA changed before RREADY");

	a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
		axi_bvalid && !axi_bready |=> axi_bvalid)
		else $error("BVALID dropped before BREADY");

endmodule

// The arbiter instance leaves the AXI inputs idle, and the slave instance the arbiter inputs
bind result_store xc_assertions u_arb_assertions (
	.clk(clk),
	.rst(rst),
	.req(req_vec),
	.gnt(gnt_vec),
	.rd_gnt(sel_valid && !sel_we),
	.rvalid(rvalid_q),
	.axi_rvalid(1'b0),
	.axi_rready(1'b0),
	.axi_rdata(32'h0),
	.axi_bvalid(1'b0),
	.axi_bready(1'b0)
);

bind xc_control xc_assertions u_axi_assertions (
	.clk(clk),
	.rst(rst),
	.req(3'b000),
	.gnt(3'b000),
	.rd_gnt(1'b0),
	.rvalid(3'b000),
	.axi_rvalid(s_rvalid),
	.axi_rready(s_rready),
	.axi_rdata(s_rdata),
	.axi_bvalid(s_bvalid),
	.axi_bready(s_bready)
);

`default_nettype wire

// File: verif/xc_tb.sv
// Cross-correlator core testbench
`timescale 1ns/1ps
`default_nettype none

module xc_tb import xc_pkg::*; ();

	localparam int LINES_N = 8;
	localparam int RES = 8;
	localparam int SAT_MAX = 2**RES - 1;

	// Five frames of at most 300 cycles plus about 200 AXI accesses of a few
	// cycles each come to a few thousand cycles, so this leaves a wide margin
	localparam int MAX_CYCLES = 20000;

	logic clk;
	logic rst;
	logic [LINES_N-1:0] lines;
	logic [ADDR_W-1:0] s_awaddr;
	logic s_awvalid;
	logic s_awready;
	logic [DATA_W-1:0] s_wdata;
	logic [DATA_W/8-1:0] s_wstrb;
	logic s_wvalid;
	logic s_wready;
	logic [1:0] s_bresp;
	logic s_bvalid;
	logic s_bready;
	logic [ADDR_W-1:0] s_araddr;
	logic s_arvalid;
	logic s_arready;
	logic [DATA_W-1:0] s_rdata;
	logic [1:0] s_rresp;
	logic s_rvalid;
	logic s_rready;

	integer seed;
	int error_count;
	int tests_run;
	int tests_failed;
	int cycle_count;
	logic [LINES_N-1:0] pattern_a;
	logic [LINES_N-1:0] pattern_b;

	xc_core #(
		.NUM_LINES(LINES_N),
		.RESOLUTION(RES)
	) UUT (
		.clk(clk),
		.rst(rst),
		.lines(lines),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready)
	);

	always #50 clk = ~clk;

	// Watchdog on the whole run
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
			$display("Regression failed");
			$finish;
		end
	end

	// **********************************************************
	// Reference model
	// **********************************************************

	// A high line counts every cycle of the frame, up to the counter limit
	function automatic logic [DATA_W-1:0] line_ref(input logic [LINES_N-1:0] pattern,
			input int line, input int frame_len);
		if (!pattern[line])
			return '0;
		return (frame_len > SAT_MAX) ? SAT_MAX : frame_len;
	endfunction

	function automatic logic [DATA_W-1:0] pair_ref(input logic [LINES_N-1:0] pattern,
			input int i, input int j, input int frame_len);
		if (!(pattern[i] && pattern[j]))
			return '0;
		return (frame_len > SAT_MAX) ? SAT_MAX : frame_len;
	endfunction

	// **********************************************************
	// Compare tasks
	// **********************************************************

	task automatic check_data(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s: expected 0x%08h, got 0x%08h", $time, name,
				expected, actual);
			error_count++;
		end
	endtask

	task automatic check_resp(input string name, input resp_e expected, input resp_e actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns %s: expected %s, got %s (%0d)", $time, name,
				expected.name(), actual.name(), actual);
			error_count++;
		end
	endtask

	// **********************************************************
	// AXI4-Lite master tasks
	// **********************************************************

	// Ready is combinational, so it is sampled a moment after the falling edge
	task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			output resp_e resp);
		@(negedge clk);
		s_awaddr = addr;
		s_awvalid = 1'b1;
		s_wdata = data;
		s_wstrb = '1;
		s_wvalid = 1'b1;
		#1;
		while (!s_awready) begin
			@(negedge clk);
			#1;
		end
		// AW and W are taken on the same cycle
		check_data("s_wready", 32'd1, DATA_W'(s_wready));
		@(negedge clk);
		s_awvalid = 1'b0;
		s_wvalid = 1'b0;
		s_bready = 1'b1;
		while (!s_bvalid)
			@(negedge clk);
		resp = resp_e'(s_bresp);
		@(negedge clk);
		s_bready = 1'b0;
	endtask

	// With hold above zero RREADY stays low for that many cycles after RVALID
	task automatic axi_read(input logic [ADDR_W-1:0] addr, input int hold,
			output logic [DATA_W-1:0] data, output resp_e resp);
		@(negedge clk);
		s_araddr = addr;
		s_arvalid = 1'b1;
		#1;
		while (!s_arready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		s_arvalid = 1'b0;
		s_rready = (hold == 0);
		while (!s_rvalid)
			@(negedge clk);
		data = s_rdata;
		resp = resp_e'(s_rresp);
		for (int k = 0; k < hold; k++) begin
			@(negedge clk);
			if (!s_rvalid) begin
				$display("RVALID dropped at %0t ns while RREADY was held low", $time);
				error_count++;
			end
			check_data("s_rdata while held", data, s_rdata);
		end
		s_rready = 1'b1;
		@(negedge clk);
		s_rready = 1'b0;
	endtask

	// **********************************************************
	// Frame control and result checks
	// **********************************************************

	// Runs with a static pattern until the given number of frames have drained
	task automatic run_frames(input int frame_len, input logic [LINES_N-1:0] pattern,
			input int frames);
		logic [DATA_W-1:0] base;
		logic [DATA_W-1:0] done;
		resp_e resp;
		@(negedge clk);
		lines = pattern;
		axi_write(REG_FRAME_LEN, DATA_W'(frame_len), resp);
		axi_read(REG_FRAMES_DONE, 0, base, resp);
		axi_write(REG_CTRL, 32'h1, resp);
		done = base;
		while (done < base + DATA_W'(frames))
			axi_read(REG_FRAMES_DONE, 0, done, resp);
		axi_write(REG_CTRL, 32'h0, resp);
	endtask

	task automatic verify_results(input logic [LINES_N-1:0] pattern, input int frame_len);
		logic [DATA_W-1:0] data;
		resp_e resp;
		int p;
		for (int i = 0; i < LINES_N; i++) begin
			axi_read(LINE_BASE_ADDR + ADDR_W'(4 * i), 0, data, resp);
			check_resp($sformatf("s_rresp line %0d", i), RESP_OKAY, resp);
			check_data($sformatf("s_rdata line %0d", i), line_ref(pattern, i, frame_len), data);
		end
		// Pair words follow the lexicographic (i, j) order
		p = 0;
		for (int i = 0; i < LINES_N; i++) begin
			for (int j = i + 1; j < LINES_N; j++) begin
				axi_read(PAIR_BASE_ADDR + ADDR_W'(4 * p), 0, data, resp);
				check_resp($sformatf("s_rresp pair %0d", p), RESP_OKAY, resp);
				check_data($sformatf("s_rdata pair (%0d,%0d)", i, j),
					pair_ref(pattern, i, j, frame_len), data);
				p++;
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
		end
	endtask

	// **********************************************************
	// Directed tests
	// **********************************************************

	task automatic reset_values();
		logic [DATA_W-1:0] data;
		resp_e resp;
		int errs;
		errs = error_count;
		axi_read(REG_CTRL, 0, data, resp);
		check_resp("s_rresp CTRL", RESP_OKAY, resp);
		check_data("s_rdata CTRL", 32'h0, data);
		axi_read(REG_FRAME_LEN, 0, data, resp);
		check_resp("s_rresp FRAME_LEN", RESP_OKAY, resp);
		check_data("s_rdata FRAME_LEN", 32'd128, data);
		axi_read(REG_FRAMES_DONE, 0, data, resp);
		check_resp("s_rresp FRAMES_DONE", RESP_OKAY, resp);
		check_data("s_rdata FRAMES_DONE", 32'h0, data);
		axi_read(LINE_BASE_ADDR, 0, data, resp);
		check_resp("s_rresp line 0", RESP_OKAY, resp);
		check_data("s_rdata line 0", 32'h0, data);
		report_test("reset values", errs);
	endtask

	task automatic register_access();
		logic [DATA_W-1:0] data;
		resp_e resp;
		int errs;
		errs = error_count;
		axi_write(REG_FRAME_LEN, 32'd200, resp);
		check_resp("s_bresp FRAME_LEN", RESP_OKAY, resp);
		axi_read(REG_FRAME_LEN, 0, data, resp);
		check_data("s_rdata FRAME_LEN", 32'd200, data);
		// Too short a frame is raised to the minimum
		axi_write(REG_FRAME_LEN, 32'd10, resp);
		axi_read(REG_FRAME_LEN, 0, data, resp);
		check_data("s_rdata FRAME_LEN", 32'd128, data);
		axi_write(REG_FRAMES_DONE, 32'd5, resp);
		check_resp("s_bresp FRAMES_DONE", RESP_SLVERR, resp);
		axi_read(12'h300, 0, data, resp);
		check_resp("s_rresp 0x300", RESP_SLVERR, resp);
		// No frame has run yet, so the count is still zero
		axi_read(REG_FRAMES_DONE, 0, data, resp);
		check_data("s_rdata FRAMES_DONE", 32'h0, data);
		report_test("register access", errs);
	endtask

	task automatic static_levels();
		int errs;
		errs = error_count;
		run_frames(200, '0, 1);
		verify_results('0, 200);
		// Long enough to push the 8-bit counters into saturation
		run_frames(300, '1, 1);
		verify_results('1, 300);
		report_test("all low and all high", errs);
	endtask

	task automatic random_pattern();
		logic [31:0] rnd;
		int errs;
		errs = error_count;
		rnd = $random(seed);
		pattern_a = rnd[LINES_N-1:0];
		run_frames(128, pattern_a, 1);
		verify_results(pattern_a, 128);
		report_test($sformatf("random pattern 0x%02h", pattern_a), errs);
	endtask

	// Two back-to-back frames; a carried count would double and saturate
	task automatic frame_isolation();
		logic [31:0] rnd;
		int errs;
		errs = error_count;
		rnd = $random(seed);
		pattern_b = rnd[LINES_N-1:0];
		if (pattern_b == pattern_a)
			pattern_b = ~pattern_a;
		run_frames(128, pattern_b, 2);
		verify_results(pattern_b, 128);
		report_test($sformatf("new pattern 0x%02h over two frames", pattern_b), errs);
	endtask

	task automatic read_backpressure();
		logic [DATA_W-1:0] data;
		resp_e resp;
		int errs;
		errs = error_count;
		axi_read(LINE_BASE_ADDR + 12'h00c, 6, data, resp);
		check_resp("s_rresp line 3", RESP_OKAY, resp);
		check_data("s_rdata line 3", line_ref(pattern_b, 3, 128), data);
		// Pair 27 is (6,7), the last word of the map
		axi_read(PAIR_BASE_ADDR + 12'h06c, 4, data, resp);
		check_resp("s_rresp pair 27", RESP_OKAY, resp);
		check_data("s_rdata pair (6,7)", pair_ref(pattern_b, 6, 7, 128), data);
		report_test("read back-pressure", errs);
	endtask

	// **********************************************************
	// Main sequence
	// **********************************************************

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		lines = '0;
		s_awaddr = '0;
		s_awvalid = 1'b0;
		s_wdata = '0;
		s_wstrb = '0;
		s_wvalid = 1'b0;
		s_bready = 1'b0;
		s_araddr = '0;
		s_arvalid = 1'b0;
		s_rready = 1'b0;
		seed = 32'h2079fd01;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		cycle_count = 0;
		pattern_a = '0;
		pattern_b = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		reset_values();
		register_access();
		static_levels();
		random_pattern();
		frame_isolation();
		read_backpressure();

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/coincidence_counter.sv
// Per-pair coincidence counters
`timescale 1ns/1ps
`default_nettype none

module coincidence_counter import xc_pkg::*; #(
	parameter int NUM_LINES = 8,
	parameter int RESOLUTION = 24
) (
	input wire clk,
	input wire rst,
	input wire [NUM_LINES-1:0] lines,
	input wire enable,
	input wire frame_end,
	result_bus_if.requester bus,
	output logic busy
);

	localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam int IDX_W = (NUM_PAIRS > 1) ? $clog2(NUM_PAIRS) : 1;

	logic [NUM_PAIRS-1:0] hit;
	logic [RESOLUTION-1:0] cnt [NUM_PAIRS];
	logic [RESOLUTION-1:0] cnt_next [NUM_PAIRS];
	logic [RESOLUTION-1:0] snap [NUM_PAIRS];
	dump_state_e state;
	logic [IDX_W-1:0] idx;

	// **********************************************************
	// Pair decode
	// **********************************************************

	// Pairs run in lexicographic order of (i, j) with i below j
	// Row i starts at i*NUM_LINES - i*(i+1)/2
	for (genvar i = 0; i < NUM_LINES; i++) begin : g_row
		for (genvar j = i + 1; j < NUM_LINES; j++) begin : g_col
			assign hit[i * NUM_LINES - i * (i + 1) / 2 + j - i - 1] = lines[i] & lines[j];
		end
	end

	// **********************************************************
	// Saturating pair counters
	// **********************************************************

	always_comb begin
		for (int p = 0; p < NUM_PAIRS; p++) begin
			cnt_next[p] = cnt[p];
			if (hit[p] && (cnt[p] != {RESOLUTION{1'b1}}))
				cnt_next[p] = cnt[p] + 1'b1;
		end
	end

	// Disabling the frame clears all pairs
	always_ff @(posedge clk) begin
		if (rst || !enable || frame_end)
			cnt <= '{default: '0};
		else
			cnt <= cnt_next;
	end

	// Snapshot includes the coincidence seen on the frame_end cycle
	always_ff @(posedge clk) begin
		if (frame_end)
			snap <= cnt_next;
	end

	// **********************************************************
	// Dump to PAIR_BASE plus pair index
	// **********************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DUMP_IDLE;
			idx <= '0;
		end else begin
			case (state)
				DUMP_IDLE: begin
					if (frame_end) begin
						idx <= '0;
						state <= DUMP_REQ;
					end
				end
				DUMP_REQ: begin
					if (bus.gnt)
						state <= (idx == IDX_W'(NUM_PAIRS - 1)) ? DUMP_IDLE : DUMP_NEXT;
				end
				DUMP_NEXT: begin
					// One gap cycle per word lets the other requesters in
					idx <= idx + 1'b1;
					state <= DUMP_REQ;
				end
				default: state <= DUMP_IDLE;
			endcase
		end
	end

	assign bus.req = (state == DUMP_REQ);
	assign bus.we = 1'b1;
	assign bus.addr = MEM_AW'(PAIR_BASE) + MEM_AW'(idx);
	assign bus.wdata = DATA_W'(snap[idx]);

	assign busy = (state != DUMP_IDLE);

endmodule

`default_nettype wire

// File: verilog/line_counter.sv
// Per-line pulse counters
`timescale 1ns/1ps
`default_nettype none

module line_counter import xc_pkg::*; #(
	parameter int NUM_LINES = 8,
	parameter int RESOLUTION = 24
) (
	input wire clk,
	input wire rst,
	input wire [NUM_LINES-1:0] lines,
	input wire enable,
	input wire frame_end,
	result_bus_if.requester bus,
	output logic busy
);

	localparam int IDX_W = (NUM_LINES > 1) ? $clog2(NUM_LINES) : 1;

	logic [RESOLUTION-1:0] cnt [NUM_LINES];
	logic [RESOLUTION-1:0] cnt_next [NUM_LINES];
	logic [RESOLUTION-1:0] snap [NUM_LINES];
	dump_state_e state;
	logic [IDX_W-1:0] idx;

	// **********************************************************
	// Live counters
	// **********************************************************

	// Each count sticks at all ones once it gets there
	always_comb begin
		for (int i = 0; i < NUM_LINES; i++) begin
			cnt_next[i] = cnt[i];
			if (lines[i] && (cnt[i] != {RESOLUTION{1'b1}}))
				cnt_next[i] = cnt[i] + 1'b1;
		end
	end

	// The frame_end cycle still counts, so it goes into the snapshot
	// and the live counters start the next frame from zero
	always_ff @(posedge clk) begin
		if (rst || !enable || frame_end)
			cnt <= '{default: '0};
		else
			cnt <= cnt_next;
	end

	always_ff @(posedge clk) begin
		if (frame_end)
			snap <= cnt_next;
	end

	// **********************************************************
	// Dump to result words 0 to NUM_LINES-1
	// **********************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= DUMP_IDLE;
			idx <= '0;
		end else begin
			case (state)
				DUMP_IDLE: begin
					if (frame_end) begin
						idx <= '0;
						state <= DUMP_REQ;
					end
				end
				DUMP_REQ: begin
					// Last word granted ends the dump
					if (bus.gnt)
						state <= (idx == IDX_W'(NUM_LINES - 1)) ? DUMP_IDLE : DUMP_NEXT;
				end
				DUMP_NEXT: begin
					idx <= idx + 1'b1;
					state <= DUMP_REQ;
				end
				default: state <= DUMP_IDLE;
			endcase
		end
	end

	assign bus.req = (state == DUMP_REQ);
	assign bus.we = 1'b1;
	assign bus.addr = MEM_AW'(idx);
	assign bus.wdata = DATA_W'(snap[idx]);

	assign busy = (state != DUMP_IDLE);

endmodule

`default_nettype wire

// File: verilog/result_bus_if.sv
// Result memory request bus
`timescale 1ns/1ps
`default_nettype none

interface result_bus_if import xc_pkg::*; ();

	// Request side
	// A requester keeps addr, we and wdata stable from req until gnt
	logic req;
	logic we;
	logic [MEM_AW-1:0] addr;
	logic [DATA_W-1:0] wdata;

	// Store side
	// The access takes place on the single gnt cycle
	logic gnt;

	// Read data arrives exactly one cycle after the grant of a read
	logic [DATA_W-1:0] rdata;
	logic rvalid;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input gnt,
		input rdata,
		input rvalid
	);

	modport store (
		input req,
		input we,
		input addr,
		input wdata,
		output gnt,
		output rdata,
		output rvalid
	);

endinterface

`default_nettype wire

// File: verilog/result_store.sv
// Result memory with round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module result_store import xc_pkg::*; (
	input wire clk,
	input wire rst,
	result_bus_if.store lines_bus,
	result_bus_if.store pairs_bus,
	result_bus_if.store host_bus
);

	logic [DATA_W-1:0] mem [2**MEM_AW];
	requester_e prio;
	requester_e sel;
	logic sel_valid;
	logic [2:0] req_vec;
	logic [2:0] gnt_vec;
	logic sel_we;
	logic [MEM_AW-1:0] sel_addr;
	logic [DATA_W-1:0] sel_wdata;
	logic [DATA_W-1:0] rdata_q;
	logic [2:0] rvalid_q;

	// **********************************************************
	// Arbitration
	// **********************************************************

	// Bit positions follow the requester_e values
	assign req_vec = {host_bus.req, pairs_bus.req, lines_bus.req};

	// Search from prio onwards; the loop runs backwards so the
	// nearest requester to prio is the last one written and wins
	always_comb begin
		int cand;
		sel = prio;
		sel_valid = 1'b0;
		for (int k = 2; k >= 0; k--) begin
			cand = (int'(prio) + k) % 3;
			if (req_vec[cand]) begin
				sel = requester_e'(cand);
				sel_valid = 1'b1;
			end
		end
	end

	assign gnt_vec = sel_valid ? (3'b001 << sel) : 3'b000;

	assign lines_bus.gnt = gnt_vec[REQ_LINES];
	assign pairs_bus.gnt = gnt_vec[REQ_PAIRS];
	assign host_bus.gnt = gnt_vec[REQ_HOST];

	// Route the granted request to the RAM port
	always_comb begin
		case (sel)
			REQ_PAIRS: begin
				sel_we = pairs_bus.we;
				sel_addr = pairs_bus.addr;
				sel_wdata = pairs_bus.wdata;
			end
			REQ_HOST: begin
				sel_we = host_bus.we;
				sel_addr = host_bus.addr;
				sel_wdata = host_bus.wdata;
			end
			default: begin
				sel_we = lines_bus.we;
				sel_addr = lines_bus.addr;
				sel_wdata = lines_bus.wdata;
			end
		endcase
	end

	// **********************************************************
	// RAM and pointer
	// **********************************************************

	// Reset clears every result word, so results read zero before the first frame
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int a = 0; a < 2**MEM_AW; a++)
				mem[a] <= '0;
		end else if (sel_valid) begin
			if (sel_we)
				mem[sel_addr] <= sel_wdata;
			else
				rdata_q <= mem[sel_addr];
		end
	end

	// The requester after the one just served gets first turn next
	always_ff @(posedge clk) begin
		if (rst) begin
			prio <= REQ_LINES;
			rvalid_q <= 3'b000;
		end else begin
			rvalid_q <= sel_we ? 3'b000 : gnt_vec;
			if (sel_valid)
				prio <= (sel == REQ_HOST) ? REQ_LINES : requester_e'(sel + 2'd1);
		end
	end

	// Read data goes to everyone, rvalid only to the reader
	assign lines_bus.rdata = rdata_q;
	assign pairs_bus.rdata = rdata_q;
	assign host_bus.rdata = rdata_q;
	assign lines_bus.rvalid = rvalid_q[REQ_LINES];
	assign pairs_bus.rvalid = rvalid_q[REQ_PAIRS];
	assign host_bus.rvalid = rvalid_q[REQ_HOST];

endmodule

`default_nettype wire

// File: verilog/xc_control.sv
// AXI4-Lite control slave and frame timer
`timescale 1ns/1ps
`default_nettype none

module xc_control import xc_pkg::*; #(
	parameter int NUM_LINES = 8
) (
	input wire clk,
	input wire rst,
	input wire [ADDR_W-1:0] s_awaddr,
	input wire s_awvalid,
	output logic s_awready,
	input wire [DATA_W-1:0] s_wdata,
	input wire [DATA_W/8-1:0] s_wstrb,
	input wire s_wvalid,
	output logic s_wready,
	output resp_e s_bresp,
	output logic s_bvalid,
	input wire s_bready,
	input wire [ADDR_W-1:0] s_araddr,
	input wire s_arvalid,
	output logic s_arready,
	output logic [DATA_W-1:0] s_rdata,
	output resp_e s_rresp,
	output logic s_rvalid,
	input wire s_rready,
	result_bus_if.requester host_bus,
	output logic frame_end,
	output logic enable,
	input wire line_busy,
	input wire pair_busy
);

	localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2;
	localparam logic [ADDR_W-1:0] LINE_END = LINE_BASE_ADDR + ADDR_W'(4 * NUM_LINES);
	localparam logic [ADDR_W-1:0] PAIR_END = PAIR_BASE_ADDR + ADDR_W'(4 * NUM_PAIRS);

	axi_state_e state;
	logic wr_fire;
	logic rd_fire;
	logic wr_ok;
	logic rd_is_line;
	logic rd_is_pair;
	logic [ADDR_W-1:0] rd_off;
	logic [DATA_W-1:0] wr_frame_len;
	logic [DATA_W-1:0] frame_len_q;
	logic [DATA_W-1:0] frames_done_q;
	logic [DATA_W-1:0] timer_q;
	logic done_pending;
	logic host_req_q;
	logic [MEM_AW-1:0] host_addr_q;

	// Byte lanes with a strobe take the new data
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_val,
			input logic [DATA_W-1:0] new_val, input logic [DATA_W/8-1:0] strb);
		logic [DATA_W-1:0] res;
		res = old_val;
		for (int b = 0; b < DATA_W / 8; b++) begin
			if (strb[b])
				res[8*b +: 8] = new_val[8*b +: 8];
		end
		return res;
	endfunction

	// **********************************************************
	// AXI handshakes and decode
	// **********************************************************

	// AW and W go together, and a write wins over a read
	assign wr_fire = (state == AXI_IDLE) && s_awvalid && s_wvalid;
	assign rd_fire = (state == AXI_IDLE) && !wr_fire && s_arvalid;
	assign s_awready = wr_fire;
	assign s_wready = wr_fire;
	assign s_arready = rd_fire;

	// Only CTRL and FRAME_LEN are writable
	assign wr_ok = (s_awaddr == REG_CTRL) || (s_awaddr == REG_FRAME_LEN);

	assign rd_is_line = (s_araddr >= LINE_BASE_ADDR) && (s_araddr < LINE_END);
	assign rd_is_pair = (s_araddr >= PAIR_BASE_ADDR) && (s_araddr < PAIR_END);
	assign rd_off = s_araddr - (rd_is_line ? LINE_BASE_ADDR : PAIR_BASE_ADDR);

	// Short frames are raised to the minimum
	always_comb begin
		wr_frame_len = merge_bytes(frame_len_q, s_wdata, s_wstrb);
		if (wr_frame_len < DATA_W'(MIN_FRAME_LEN))
			wr_frame_len = DATA_W'(MIN_FRAME_LEN);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= AXI_IDLE;
			s_bvalid <= 1'b0;
			s_rvalid <= 1'b0;
			host_req_q <= 1'b0;
			enable <= 1'b0;
			frame_len_q <= DATA_W'(MIN_FRAME_LEN);
		end else begin
			case (state)
				AXI_IDLE: begin
					if (wr_fire) begin
						s_bvalid <= 1'b1;
						state <= AXI_RESP;
						if ((s_awaddr == REG_CTRL) && s_wstrb[0])
							enable <= s_wdata[0];
						else if (s_awaddr == REG_FRAME_LEN)
							frame_len_q <= wr_frame_len;
					end else if (rd_fire) begin
						if (rd_is_line || rd_is_pair) begin
							host_req_q <= 1'b1;
							state <= AXI_MEM_WAIT;
						end else begin
							s_rvalid <= 1'b1;
							state <= AXI_RESP;
						end
					end
				end
				AXI_MEM_WAIT: begin
					if (host_bus.gnt)
						host_req_q <= 1'b0;
					if (host_bus.rvalid) begin
						s_rvalid <= 1'b1;
						state <= AXI_RESP;
					end
				end
				AXI_RESP: begin
					// A held response keeps the channel closed
					if (s_bvalid && s_bready) begin
						s_bvalid <= 1'b0;
						state <= AXI_IDLE;
					end
					if (s_rvalid && s_rready) begin
						s_rvalid <= 1'b0;
						state <= AXI_IDLE;
					end
				end
				default: state <= AXI_IDLE;
			endcase
		end
	end

	// Response payload
	always_ff @(posedge clk) begin
		if (wr_fire)
			s_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (rd_fire) begin
			host_addr_q <= rd_is_line ? MEM_AW'(rd_off[ADDR_W-1:2])
				: MEM_AW'(PAIR_BASE) + MEM_AW'(rd_off[ADDR_W-1:2]);
			s_rresp <= RESP_OKAY;
			case (s_araddr)
				REG_CTRL: s_rdata <= DATA_W'(enable);
				REG_FRAME_LEN: s_rdata <= frame_len_q;
				REG_FRAMES_DONE: s_rdata <= frames_done_q;
				default: begin
					s_rdata <= '0;
					if (!rd_is_line && !rd_is_pair)
						s_rresp <= RESP_SLVERR;
				end
			endcase
		end
		if ((state == AXI_MEM_WAIT) && host_bus.rvalid)
			s_rdata <= host_bus.rdata;
	end

	// The host only ever reads results
	assign host_bus.req = host_req_q;
	assign host_bus.we = 1'b0;
	assign host_bus.addr = host_addr_q;
	assign host_bus.wdata = '0;

	// **********************************************************
	// Frame timer and frame count
	// **********************************************************

	// The comparison also ends a frame that FRAME_LEN shortened mid-way
	assign frame_end = enable && (timer_q >= frame_len_q - 1'b1);

	always_ff @(posedge clk) begin
		if (rst || !enable) begin
			timer_q <= '0;
			done_pending <= 1'b0;
		end else begin
			timer_q <= frame_end ? '0 : timer_q + 1'b1;
			if (frame_end)
				done_pending <= 1'b1;
			else if (!line_busy && !pair_busy)
				done_pending <= 1'b0;
		end
	end

	// A frame is done once both dumps have drained
	always_ff @(posedge clk) begin
		if (rst)
			frames_done_q <= '0;
		else if (enable && done_pending && !frame_end && !line_busy && !pair_busy)
			frames_done_q <= frames_done_q + 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/xc_core.sv
// Cross-correlator acquisition core
`timescale 1ns/1ps
`default_nettype none

module xc_core import xc_pkg::*; #(
	parameter int NUM_LINES = 8,
	parameter int RESOLUTION = 24
) (
	input wire clk,
	input wire rst,
	input wire [NUM_LINES-1:0] lines,
	input wire [ADDR_W-1:0] s_awaddr,
	input wire s_awvalid,
	output wire s_awready,
	input wire [DATA_W-1:0] s_wdata,
	input wire [DATA_W/8-1:0] s_wstrb,
	input wire s_wvalid,
	output wire s_wready,
	output wire [1:0] s_bresp,
	output wire s_bvalid,
	input wire s_bready,
	input wire [ADDR_W-1:0] s_araddr,
	input wire s_arvalid,
	output wire s_arready,
	output wire [DATA_W-1:0] s_rdata,
	output wire [1:0] s_rresp,
	output wire s_rvalid,
	input wire s_rready
);

	logic enable;
	logic frame_end;
	logic line_busy;
	logic pair_busy;

	// One memory bus per requester
	result_bus_if lines_bus ();
	result_bus_if pairs_bus ();
	result_bus_if host_bus ();

	xc_control #(
		.NUM_LINES(NUM_LINES)
	) u_control (
		.clk(clk),
		.rst(rst),
		.s_awaddr(s_awaddr),
		.s_awvalid(s_awvalid),
		.s_awready(s_awready),
		.s_wdata(s_wdata),
		.s_wstrb(s_wstrb),
		.s_wvalid(s_wvalid),
		.s_wready(s_wready),
		.s_bresp(s_bresp),
		.s_bvalid(s_bvalid),
		.s_bready(s_bready),
		.s_araddr(s_araddr),
		.s_arvalid(s_arvalid),
		.s_arready(s_arready),
		.s_rdata(s_rdata),
		.s_rresp(s_rresp),
		.s_rvalid(s_rvalid),
		.s_rready(s_rready),
		.host_bus(host_bus.requester),
		.frame_end(frame_end),
		.enable(enable),
		.line_busy(line_busy),
		.pair_busy(pair_busy)
	);

	// Autocorrelation and cross-correlation units run side by side
	line_counter #(
		.NUM_LINES(NUM_LINES),
		.RESOLUTION(RESOLUTION)
	) u_line_counter (
		.clk(clk),
		.rst(rst),
		.lines(lines),
		.enable(enable),
		.frame_end(frame_end),
		.bus(lines_bus.requester),
		.busy(line_busy)
	);

	coincidence_counter #(
		.NUM_LINES(NUM_LINES),
		.RESOLUTION(RESOLUTION)
	) u_coincidence_counter (
		.clk(clk),
		.rst(rst),
		.lines(lines),
		.enable(enable),
		.frame_end(frame_end),
		.bus(pairs_bus.requester),
		.busy(pair_busy)
	);

	result_store u_result_store (
		.clk(clk),
		.rst(rst),
		.lines_bus(lines_bus.store),
		.pairs_bus(pairs_bus.store),
		.host_bus(host_bus.store)
	);

endmodule

`default_nettype wire

// File: verilog/xc_pkg.sv
// Cross-correlator shared definitions
`default_nettype none

package xc_pkg;

	// **********************************************************
	// Bus and memory widths
	// **********************************************************

	// AXI4-Lite byte address and data width
	localparam int ADDR_W = 12;
	localparam int DATA_W = 32;

	// Result memory has 128 words
	// Words 0 to 31 hold line counts and words 32 to 127 hold pair counts
	localparam int MEM_AW = 7;
	localparam int PAIR_BASE = 32;

	// **********************************************************
	// AXI address map
	// **********************************************************

	localparam logic [ADDR_W-1:0] REG_CTRL = 12'h000;
	localparam logic [ADDR_W-1:0] REG_FRAME_LEN = 12'h004;
	localparam logic [ADDR_W-1:0] REG_FRAMES_DONE = 12'h008;
	localparam logic [ADDR_W-1:0] LINE_BASE_ADDR = 12'h100;
	localparam logic [ADDR_W-1:0] PAIR_BASE_ADDR = 12'h200;

	// Shortest accepted frame, long enough for the 28 pair words to be dumped
	localparam int MIN_FRAME_LEN = 128;

	// **********************************************************
	// Enumerations
	// **********************************************************

	// The values double as bit positions in the arbiter request vector
	typedef enum logic [1:0] {
		REQ_LINES = 2'd0,
		REQ_PAIRS = 2'd1,
		REQ_HOST = 2'd2
	} requester_e;

	typedef enum logic [1:0] {DUMP_IDLE, DUMP_REQ, DUMP_NEXT} dump_state_e;

	typedef enum logic [1:0] {AXI_IDLE, AXI_MEM_WAIT, AXI_RESP} axi_state_e;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'd0,
		RESP_SLVERR = 2'd2
	} resp_e;

endpackage

`default_nettype wire

// File: vlog.f
verilog/xc_pkg.sv
verilog/result_bus_if.sv
verilog/line_counter.sv
verilog/coincidence_counter.sv
verilog/result_store.sv
verilog/xc_control.sv
verilog/xc_core.sv
verif/xc_assertions.sv
verif/xc_tb.sv
